// File: include/bist_macros.svh
`ifndef BIST_MACROS_SVH
`define BIST_MACROS_SVH

// ==============================
// SRAM pins
`define SRAM_ADDR_WIDTH 20
`define SRAM_DATA_WIDTH 16

// ==============================
// test size
`define NUM_LANES       4
`define NUM_REGIONS     16
`define REGION_WORDS    32

`define LANE_ID_WIDTH   2   // log2 of lanes
`define REGION_ID_WIDTH 4   // log2 of regions
`define WORD_OFF_WIDTH  5   // log2 of region words
`define ERR_CNT_WIDTH   6   // 0 to 32 errors

`define PATTERN_KEY     16'h5A5A  // xor key on the address

`endif

// File: rtl/bist_pkg.sv
`include "bist_macros.svh"

package bist_pkg;

    // ==============================
    // vectors
    typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;
    typedef logic [`SRAM_DATA_WIDTH-1:0] sram_data_t;
    typedef logic [`LANE_ID_WIDTH-1:0]   lane_id_t;
    typedef logic [`REGION_ID_WIDTH-1:0] region_id_t;
    typedef logic [`WORD_OFF_WIDTH-1:0]  word_off_t;
    typedef logic [`ERR_CNT_WIDTH-1:0]   err_cnt_t;

    // ==============================
    // bundles
    typedef struct packed {
        logic       wr;    // 1 write, 0 read
        sram_addr_t addr;
        sram_data_t data;  // write data, or expected word on a read
    } mem_req_t;

    typedef struct packed {
        region_id_t region;
        err_cnt_t   errs;
    } region_result_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        REPORT
    } lane_state_e;

    // next requester after last, wrapping; returns last if none
    function automatic lane_id_t rr_next(input logic [`NUM_LANES-1:0] req,
                                         input lane_id_t last);
        lane_id_t cand;
        lane_id_t pick;
        pick = last;
        for (int i = `NUM_LANES; i >= 1; i--) begin  // nearest candidate wins
            cand = lane_id_t'(last + i);
            if (req[cand]) begin
                pick = cand;
            end
        end
        return pick;
    endfunction

endpackage

// File: rtl/region_dispatcher.sv
`include "bist_macros.svh"

module region_dispatcher
    import bist_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic [`NUM_LANES-1:0] i_lane_busy,
    output logic [`NUM_LANES-1:0] o_assign,
    output region_id_t            o_region
);

    logic                  active_q;
    region_id_t            next_q;
    logic [`NUM_LANES-1:0] idle;
    logic [`NUM_LANES-1:0] pick;

    assign idle = ~i_lane_busy & ~o_assign;  // pulsed lane not busy yet
    assign pick = idle & (~idle + 1'b1);     // lowest set bit

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            active_q <= 1'b0;
            next_q   <= '0;
            o_assign <= '0;
        end else begin
            o_assign <= '0;
            if (i_start) begin
                active_q <= 1'b1;
                next_q   <= '0;
            end else if (active_q && |idle) begin
                o_assign <= pick;
                next_q   <= next_q + 1'b1;
                if (next_q == region_id_t'(`NUM_REGIONS - 1)) begin
                    active_q <= 1'b0;  // last region handed out
                end
            end
        end
    end

    // sampled with the same edge as o_assign
    always_ff @(posedge clk) begin
        o_region <= next_q;
    end

    a_assign_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
        $onehot0(o_assign));

    // a region never goes to a lane that is still working
    a_assign_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_assign & i_lane_busy) == '0);

endmodule

// File: rtl/march_lane.sv
`include "bist_macros.svh"

module march_lane
    import bist_pkg::*;
(
    input  logic           clk,
    input  logic           i_rst_n,
    input  logic           i_assign,
    input  region_id_t     i_region,
    output logic           o_busy,
    output logic           o_req,
    output mem_req_t       o_req_data,
    input  logic           i_grant,
    input  sram_data_t     i_rdata,
    output logic           o_res_valid,
    output region_result_t o_result,
    input  logic           i_res_accept
);

    lane_state_e state_q;
    region_id_t  region_q;
    word_off_t   off_q;
    err_cnt_t    err_q;
    sram_addr_t  addr;
    sram_data_t  pattern;
    logic        last_word;
    logic        mismatch;

    // ==============================
    // address and pattern
    assign addr      = sram_addr_t'({region_q, off_q});  // r * REGION_WORDS + k
    assign pattern   = addr[`SRAM_DATA_WIDTH-1:0] ^ `PATTERN_KEY;
    assign last_word = (off_q == word_off_t'(`REGION_WORDS - 1));
    assign mismatch  = (i_rdata != pattern);

    assign o_busy          = (state_q != IDLE);
    assign o_req           = (state_q == WRITE) || (state_q == READ);
    assign o_req_data.wr   = (state_q == WRITE);
    assign o_req_data.addr = addr;
    assign o_req_data.data = pattern;

    assign o_res_valid     = (state_q == REPORT);
    assign o_result.region = region_q;
    assign o_result.errs   = err_q;

    // ==============================
    // lane FSM
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            off_q   <= '0;
            err_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_assign) begin
                        state_q <= WRITE;
                        off_q   <= '0;
                        err_q   <= '0;
                    end
                end
                WRITE: begin
                    if (i_grant) begin
                        off_q <= off_q + 1'b1;  // wraps to 0 for the read pass
                        if (last_word) begin
                            state_q <= READ;
                        end
                    end
                end
                READ: begin
                    if (i_grant) begin
                        off_q <= off_q + 1'b1;
                        if (mismatch) begin
                            err_q <= err_q + 1'b1;
                        end
                        if (last_word) begin
                            state_q <= REPORT;
                        end
                    end
                end
                REPORT: begin
                    if (i_res_accept) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && i_assign) begin
            region_q <= i_region;
        end
    end

    a_grant_has_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_grant |-> o_req);

endmodule

// File: rtl/sram_arbiter.sv
`include "bist_macros.svh"

module sram_arbiter
    import bist_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic [`NUM_LANES-1:0] i_req,
    input  mem_req_t              i_req_data [`NUM_LANES],
    output logic [`NUM_LANES-1:0] o_grant,
    output sram_data_t            o_rdata,
    output sram_addr_t            o_sram_addr,
    input  sram_data_t            i_sram_dq,
    output sram_data_t            o_sram_dq,
    output logic                  o_sram_ce_n,
    output logic                  o_sram_we_n,
    output logic                  o_sram_oe_n,
    output logic                  o_sram_ub_n,
    output logic                  o_sram_lb_n
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_DRIVE,   // cycle 1 of an access
        SEQ_FINISH   // cycle 2 with the grant
    } seq_state_e;

    localparam logic [`NUM_LANES-1:0] LANE0 = 1;

    seq_state_e            seq_q;
    lane_id_t              rr_ptr;  // lane of current or last access
    lane_id_t              sel_id;
    logic [`NUM_LANES-1:0] avail;
    logic                  start;
    mem_req_t              sel_req;
    sram_data_t            wdata_q;

    assign avail   = i_req & ~o_grant;  // granted lane still shows its old request
    assign sel_id  = rr_next(avail, rr_ptr);
    assign sel_req = i_req_data[sel_id];
    assign start   = (seq_q != SEQ_DRIVE) && (|avail);

    // ==============================
    // pin sequencer
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            seq_q       <= SEQ_IDLE;
            rr_ptr      <= '0;
            o_grant     <= '0;
            o_sram_ce_n <= 1'b1;
            o_sram_we_n <= 1'b1;
            o_sram_oe_n <= 1'b1;
            o_sram_ub_n <= 1'b1;
            o_sram_lb_n <= 1'b1;
        end else begin
            o_grant <= '0;
            if (seq_q == SEQ_DRIVE) begin
                seq_q       <= SEQ_FINISH;
                o_grant     <= LANE0 << rr_ptr;
                o_sram_we_n <= 1'b1;  // write lands on rising we_n
            end else if (start) begin
                seq_q       <= SEQ_DRIVE;
                rr_ptr      <= sel_id;
                o_sram_ce_n <= 1'b0;
                o_sram_ub_n <= 1'b0;
                o_sram_lb_n <= 1'b0;
                o_sram_we_n <= ~sel_req.wr;
                o_sram_oe_n <= sel_req.wr;
            end else begin
                seq_q       <= SEQ_IDLE;
                o_sram_ce_n <= 1'b1;
                o_sram_we_n <= 1'b1;
                o_sram_oe_n <= 1'b1;
                o_sram_ub_n <= 1'b1;
                o_sram_lb_n <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            o_sram_addr <= sel_req.addr;
            wdata_q     <= sel_req.data;
        end
    end

    assign o_sram_dq = o_sram_we_n ? '0 : wdata_q;
    assign o_rdata   = i_sram_dq;  // lane samples it with the grant

    a_we_oe_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(!o_sram_we_n && !o_sram_oe_n));

endmodule

// File: rtl/result_collector.sv
`include "bist_macros.svh"

module result_collector
    import bist_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic [`NUM_LANES-1:0] i_res_valid,
    input  region_result_t        i_result [`NUM_LANES],
    output logic [`NUM_LANES-1:0] o_res_accept,
    output region_result_t        o_sim_tp,
    output logic                  o_sim_retire,
    output logic                  o_done
);

    localparam int CNT_W = $clog2(`NUM_REGIONS + 1);
    localparam logic [`NUM_LANES-1:0] LANE0 = 1;

    lane_id_t              rr_ptr;
    lane_id_t              sel_id;
    logic [`NUM_LANES-1:0] waiting;
    logic [CNT_W-1:0]      retire_cnt;

    assign waiting = i_res_valid & ~o_res_accept;  // accepted lane drops next cycle
    assign sel_id  = rr_next(waiting, rr_ptr);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rr_ptr       <= '0;
            o_res_accept <= '0;
            o_sim_retire <= 1'b0;
            o_done       <= 1'b0;
            retire_cnt   <= '0;
        end else begin
            o_res_accept <= '0;
            o_sim_retire <= 1'b0;
            if (|waiting) begin
                o_res_accept <= LANE0 << sel_id;
                o_sim_retire <= 1'b1;
                rr_ptr       <= sel_id;
                retire_cnt   <= retire_cnt + 1'b1;
            end
            if (retire_cnt == CNT_W'(`NUM_REGIONS)) begin
                o_done <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|waiting) begin
            o_sim_tp <= i_result[sel_id];
        end
    end

endmodule

// File: rtl/bist_sim_top.sv
`include "bist_macros.svh"

module bist_sim_top
    import bist_pkg::*;
(
    input  logic           clk,
    input  logic           i_rst_n,
    input  logic           i_start,

    // SRAM bus
    output sram_addr_t     o_sram_addr,
    input  sram_data_t     i_sram_dq,
    output sram_data_t     o_sram_dq,
    output logic           o_sram_ce_n,
    output logic           o_sram_we_n,
    output logic           o_sram_oe_n,
    output logic           o_sram_ub_n,
    output logic           o_sram_lb_n,

    // pass/fail observation
    output region_result_t o_sim_tp,
    output logic           o_sim_retire,
    output logic           o_done
);

    logic [`NUM_LANES-1:0] lane_busy;
    logic [`NUM_LANES-1:0] lane_assign;
    logic [`NUM_LANES-1:0] lane_req;
    logic [`NUM_LANES-1:0] lane_grant;
    logic [`NUM_LANES-1:0] res_valid;
    logic [`NUM_LANES-1:0] res_accept;
    region_id_t            assign_region;
    sram_data_t            rdata;
    mem_req_t              req_data [`NUM_LANES];
    region_result_t        lane_result [`NUM_LANES];

    region_dispatcher u_dispatch (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_lane_busy (lane_busy),
        .o_assign    (lane_assign),
        .o_region    (assign_region)
    );

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        march_lane u_lane (
            .clk          (clk),
            .i_rst_n      (i_rst_n),
            .i_assign     (lane_assign[g]),
            .i_region     (assign_region),  // broadcast, only the pulsed lane takes it
            .o_busy       (lane_busy[g]),
            .o_req        (lane_req[g]),
            .o_req_data   (req_data[g]),
            .i_grant      (lane_grant[g]),
            .i_rdata      (rdata),
            .o_res_valid  (res_valid[g]),
            .o_result     (lane_result[g]),
            .i_res_accept (res_accept[g])
        );
    end

    sram_arbiter u_arb (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req       (lane_req),
        .i_req_data  (req_data),
        .o_grant     (lane_grant),
        .o_rdata     (rdata),
        .o_sram_addr (o_sram_addr),
        .i_sram_dq   (i_sram_dq),
        .o_sram_dq   (o_sram_dq),
        .o_sram_ce_n (o_sram_ce_n),
        .o_sram_we_n (o_sram_we_n),
        .o_sram_oe_n (o_sram_oe_n),
        .o_sram_ub_n (o_sram_ub_n),
        .o_sram_lb_n (o_sram_lb_n)
    );

    result_collector u_collect (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_res_valid  (res_valid),
        .i_result     (lane_result),
        .o_res_accept (res_accept),
        .o_sim_tp     (o_sim_tp),
        .o_sim_retire (o_sim_retire),
        .o_done       (o_done)
    );

endmodule

// File: sim/tb_checker.sv
`include "bist_macros.svh"

module tb_checker
    import bist_pkg::*;
#(
    parameter int NUM_FAULTS = 12
) (
    input  logic           clk,
    input  logic           i_rst_n,
    input  sram_addr_t     i_fault_addr  [NUM_FAULTS],
    input  sram_data_t     i_fault_mask  [NUM_FAULTS],
    input  sram_data_t     i_fault_stuck [NUM_FAULTS],
    input  region_result_t i_sim_tp,
    input  logic           i_sim_retire,
    input  logic           i_done,
    input  sram_addr_t     i_sram_addr,
    input  logic           i_ce_n,
    input  logic           i_we_n,
    input  logic           i_oe_n,
    input  logic           i_ub_n,
    input  logic           i_lb_n,
    output logic           o_finished,
    output int             o_errors
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          TIMEOUT_CYCLES = 20000;
    localparam int          MEM_WORDS      = `NUM_REGIONS * `REGION_WORDS;
    localparam logic [15:0] PATTERN_XOR    = 16'h5A5A;  // xor key on the address

    int   retire_seen [`NUM_REGIONS];
    int   retires;
    int   count_fails;
    int   order_fails;
    int   clean_fails;
    int   done_fails;
    int   bus_fails;
    int   timeouts;
    int   tests_failed;
    int   writes;
    int   reads;
    logic done_seen;
    logic second_phase;  // cycle 2 of an access

    // ==============================
    // model of the expected report
    function automatic err_cnt_t expected_errors(input region_id_t region);
        sram_addr_t a;
        sram_data_t pattern;
        logic       bad;
        int         count;
        count = 0;
        for (int k = 0; k < `REGION_WORDS; k++) begin
            a       = sram_addr_t'(int'(region) * `REGION_WORDS + k);
            pattern = a[15:0] ^ PATTERN_XOR;
            bad     = 1'b0;
            for (int f = 0; f < NUM_FAULTS; f++) begin
                if (i_fault_addr[f] == a &&
                    (i_fault_mask[f] & (pattern ^ i_fault_stuck[f])) != '0) begin
                    bad = 1'b1;
                end
            end
            if (bad) begin
                count++;
            end
        end
        return err_cnt_t'(count);
    endfunction

    function automatic logic region_has_fault(input region_id_t region);
        logic hit;
        hit = 1'b0;
        for (int f = 0; f < NUM_FAULTS; f++) begin
            if (i_fault_addr[f] / `REGION_WORDS == int'(region)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic score_retire(input region_result_t res);
        err_cnt_t want;
        want = expected_errors(res.region);
        retires++;
        if (res.errs != want) begin
            $display("[FAIL] %0t: region %0d expected %0d errors, got %0d",
                     $time, res.region, want, res.errs);
            count_fails++;
        end
        if (retire_seen[res.region] != 0) begin
            $display("[FAIL] %0t: region %0d retired a second time", $time, res.region);
            order_fails++;
        end
        retire_seen[res.region]++;
        if (!region_has_fault(res.region) && res.errs != '0) begin
            $display("[FAIL] %0t: fault-free region %0d reported %0d errors",
                     $time, res.region, res.errs);
            clean_fails++;
        end
        if (done_seen) begin
            $display("[FAIL] %0t: retire of region %0d after o_done", $time, res.region);
            done_fails++;
        end
    endtask

    task automatic track_done();
        if (i_done && !done_seen && retires < `NUM_REGIONS) begin
            $display("[FAIL] %0t: o_done rose after only %0d retires", $time, retires);
            done_fails++;
        end
        if (done_seen && !i_done) begin
            $display("[FAIL] %0t: o_done dropped after rising", $time);
            done_fails++;
        end
        if (i_done) begin
            done_seen = 1'b1;
        end
    endtask

    task automatic watch_bus();
        if (!i_we_n && !i_oe_n) begin
            $display("[FAIL] %0t: we_n and oe_n low together", $time);
            bus_fails++;
        end
        if (second_phase) begin
            if (i_ce_n || i_ub_n || i_lb_n || !i_we_n) begin
                $display("[FAIL] %0t: bad pins in second access cycle", $time);
                bus_fails++;
            end
            second_phase = 1'b0;
        end else if (!i_ce_n) begin
            if (i_ub_n || i_lb_n || (i_we_n && i_oe_n) || i_sram_addr >= MEM_WORDS) begin
                $display("[FAIL] %0t: bad pins in first access cycle", $time);
                bus_fails++;
            end
            if (!i_we_n) begin
                writes++;
            end else begin
                reads++;
            end
            second_phase = 1'b1;
        end else if (!i_ub_n || !i_lb_n || !i_we_n || !i_oe_n) begin
            $display("[FAIL] %0t: bus strobes low with no access", $time);
            bus_fails++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int fails);
        if (fails == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d failures", num, name, fails);
            tests_failed++;
        end
    endtask

    // ==============================
    // mid-cycle monitor with outputs settled
    always @(negedge clk) begin
        if (i_rst_n) begin
            if (i_sim_retire) begin
                score_retire(i_sim_tp);
            end
            track_done();
            watch_bus();
        end
    end

    initial begin
        int waited;
        o_finished   = 1'b0;
        o_errors     = 0;
        retires      = 0;
        count_fails  = 0;
        order_fails  = 0;
        clean_fails  = 0;
        done_fails   = 0;
        bus_fails    = 0;
        timeouts     = 0;
        tests_failed = 0;
        writes       = 0;
        reads        = 0;
        done_seen    = 1'b0;
        second_phase = 1'b0;
        for (int r = 0; r < `NUM_REGIONS; r++) begin
            retire_seen[r] = 0;
        end
        waited = 0;
        while (!i_rst_n && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (!i_rst_n) begin
            $display("reset was not released within %0d cycles", TIMEOUT_CYCLES);
            timeouts++;
        end else begin
            waited = 0;
            while (!i_done && waited < TIMEOUT_CYCLES) begin
                @(negedge clk);
                waited++;
            end
            if (!i_done) begin
                $display("o_done did not rise within %0d cycles, %0d regions retired",
                         TIMEOUT_CYCLES, retires);
                timeouts++;
            end else begin
                repeat (8) @(posedge clk);  // done must hold with no late retire
            end
        end
        for (int r = 0; r < `NUM_REGIONS; r++) begin
            if (retire_seen[r] == 0) begin
                $display("region %0d never retired", r);
                order_fails++;
            end
        end
        if (writes != MEM_WORDS || reads != MEM_WORDS) begin
            $display("saw %0d writes and %0d reads on the bus, expected %0d each",
                     writes, reads, MEM_WORDS);
            bus_fails++;
        end
        report_test(1, "error counts against model", count_fails);
        report_test(2, "each region retired once", order_fails);
        report_test(3, "fault-free regions report zero", clean_fails);
        report_test(4, "done after last retire", done_fails);
        report_test(5, "SRAM bus pin sequencing", bus_fails);
        $display("tests: %0d passed, %0d failed, %0d timeouts",
                 5 - tests_failed, tests_failed, timeouts);
        o_errors   = tests_failed + timeouts;
        o_finished = 1'b1;
    end

endmodule

// File: sim/tb_top.sv
`include "bist_macros.svh"

module tb_top
    import bist_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_FAULTS   = 12;
    localparam int MEM_WORDS    = `NUM_REGIONS * `REGION_WORDS;
    localparam int RESET_CYCLES = 16;
    localparam int END_TIMEOUT  = 50000;

    logic           clk;
    logic           rst_n;
    logic           start;
    sram_addr_t     sram_addr;
    sram_data_t     dq_to_dut;
    sram_data_t     dq_from_dut;
    logic           ce_n;
    logic           we_n;
    logic           oe_n;
    logic           ub_n;
    logic           lb_n;
    region_result_t sim_tp;
    logic           sim_retire;
    logic           done;
    logic           chk_finished;
    int             chk_errors;

    sram_data_t mem         [MEM_WORDS];
    sram_addr_t fault_addr  [NUM_FAULTS];
    sram_data_t fault_mask  [NUM_FAULTS];
    sram_data_t fault_stuck [NUM_FAULTS];
    integer     seed;
    int         start_delay;

    // ==============================
    // stuck-bit fault table
    task automatic draw_faults();
        sram_addr_t cand;
        logic       taken;
        for (int f = 0; f < NUM_FAULTS; f++) begin
            taken = 1'b1;
            while (taken) begin  // one fault per word
                cand  = sram_addr_t'($unsigned($random(seed)) % MEM_WORDS);
                taken = 1'b0;
                for (int p = 0; p < f; p++) begin
                    if (fault_addr[p] == cand) begin
                        taken = 1'b1;
                    end
                end
            end
            fault_addr[f]  = cand;
            fault_mask[f]  = sram_data_t'($random(seed));
            fault_stuck[f] = sram_data_t'($random(seed));
        end
    endtask

    function automatic sram_data_t faulty_read(input sram_addr_t addr);
        sram_data_t word;
        word = mem[addr % MEM_WORDS];
        for (int f = 0; f < NUM_FAULTS; f++) begin
            if (fault_addr[f] == addr) begin
                word = (word & ~fault_mask[f]) | (fault_stuck[f] & fault_mask[f]);
            end
        end
        return word;
    endfunction

    // ==============================
    // behavioral SRAM
    always @(negedge clk) begin
        if (!ce_n && !we_n) begin
            mem[sram_addr % MEM_WORDS] <= dq_from_dut;  // store while we_n low
        end
    end

    always @(posedge clk) begin
        #2;
        if (!ce_n && !oe_n) begin
            dq_to_dut = faulty_read(sram_addr);
        end else begin
            dq_to_dut = '0;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    bist_sim_top DUT (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_start      (start),
        .o_sram_addr  (sram_addr),
        .i_sram_dq    (dq_to_dut),
        .o_sram_dq    (dq_from_dut),
        .o_sram_ce_n  (ce_n),
        .o_sram_we_n  (we_n),
        .o_sram_oe_n  (oe_n),
        .o_sram_ub_n  (ub_n),
        .o_sram_lb_n  (lb_n),
        .o_sim_tp     (sim_tp),
        .o_sim_retire (sim_retire),
        .o_done       (done)
    );

    tb_checker #(.NUM_FAULTS(NUM_FAULTS)) u_checker (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_fault_addr  (fault_addr),
        .i_fault_mask  (fault_mask),
        .i_fault_stuck (fault_stuck),
        .i_sim_tp      (sim_tp),
        .i_sim_retire  (sim_retire),
        .i_done        (done),
        .i_sram_addr   (sram_addr),
        .i_ce_n        (ce_n),
        .i_we_n        (we_n),
        .i_oe_n        (oe_n),
        .i_ub_n        (ub_n),
        .i_lb_n        (lb_n),
        .o_finished    (chk_finished),
        .o_errors      (chk_errors)
    );

    // ==============================
    // reset, start and end of run
    initial begin
        int waited;
        seed      = 32'h2ad4_5acb;
        rst_n     = 1'b0;
        start     = 1'b0;
        dq_to_dut = '0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = sram_data_t'(a * 16'h0105) ^ 16'h3C3C;
        end
        draw_faults();
        start_delay = 1 + ($unsigned($random(seed)) % 24);
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (start_delay) @(posedge clk);
        #2 start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
        waited = 0;
        while (!chk_finished && waited < END_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!chk_finished) begin
            $display("checker did not finish within %0d cycles", END_TIMEOUT);
            $display("Simulation finished: FAIL");
        end else if (chk_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
rtl/bist_pkg.sv
rtl/region_dispatcher.sv
rtl/march_lane.sv
rtl/sram_arbiter.sv
rtl/result_collector.sv
rtl/bist_sim_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SRAM BIST testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module tb_top -f flist.f -o tb_sim; then
    echo "verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
